// File: all.f
+incdir+rtl
rtl/rv_id_pkg.sv
rtl/imm_gen.sv
rtl/ctrl_decoder.sv
rtl/operand_fwd.sv
rtl/branch_resolve.sv
rtl/id_ex_reg.sv
rtl/rv_id_stage.sv
tests/rv_id_asserts.sv
tests/tb_rv_id.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_rv_id -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_rv_id > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$log"; then
	exit 1
fi
exit 0

// File: tests/tb_rv_id.sv
`include "rv_id_consts.svh"

module tb_rv_id;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	// reset plus one cycle per issued instruction in each test
	localparam int TEST_CYCLES  = RESET_CYCLES + 1 + 8 + 7 + 4 + 5 + 26 + 4;
	localparam int WATCHDOG     = TEST_CYCLES * CLK_PERIOD * 2;

	logic					clk;
	logic					rst;
	logic [`RV_XLEN-1:0]	pc_i;
	logic [`RV_XLEN-1:0]	inst_i;
	logic					inst_valid_i;
	logic					r1_en_o;
	logic					r2_en_o;
	logic [`RV_REG_AW-1:0]	r1_addr_o;
	logic [`RV_REG_AW-1:0]	r2_addr_o;
	logic [`RV_XLEN-1:0]	r1_data_i;
	logic [`RV_XLEN-1:0]	r2_data_i;
	logic					ex_w_en_i;
	logic					ex_is_load_i;
	logic [`RV_REG_AW-1:0]	ex_w_addr_i;
	logic [`RV_XLEN-1:0]	ex_w_data_i;
	logic					mem_w_en_i;
	logic [`RV_REG_AW-1:0]	mem_w_addr_i;
	logic [`RV_XLEN-1:0]	mem_w_data_i;
	logic					stall_o;
	logic [`RV_XLEN-1:0]	pc_o;
	rv_id_pkg::alu_op_e		aluop_o;
	rv_id_pkg::alu_sel_e	alusel_o;
	logic [`RV_XLEN-1:0]	op1_o;
	logic [`RV_XLEN-1:0]	op2_o;
	logic					w_en_o;
	logic [`RV_REG_AW-1:0]	w_addr_o;
	logic [`RV_XLEN-1:0]	offset_o;
	logic					b_flag_o;
	logic [`RV_XLEN-1:0]	b_target_o;
	logic					illegal_o;
	logic					valid_o;

	logic	stall_seen;
	string	test_name;

	rv_id_stage u_rv_id_stage (.*);

	bind rv_id_stage rv_id_asserts u_rv_id_asserts (
		.clk			(clk),
		.rst			(rst),
		.ex_is_load_i	(ex_is_load_i),
		.stall_o		(stall_o),
		.valid_o		(valid_o),
		.w_en_o			(w_en_o),
		.b_flag_o		(b_flag_o)
	);

	// register file model with x0 reading 0
	assign r1_data_i = {27'b0, r1_addr_o} * 32'h0101_0101;
	assign r2_data_i = {27'b0, r2_addr_o} * 32'h0101_0101;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG);
		$display("timeout: the tests did not finish in the expected time");
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] rf_val(input logic [4:0] a);
		return {27'b0, a} * 32'h0101_0101;
	endfunction

	function automatic logic [4:0] rnd_reg();
		logic [31:0] r;
		r = $urandom_range(31, 1);
		return r[4:0];
	endfunction

	function automatic logic [31:0] r_type(input logic alt, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [11:0] imm,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
	endfunction

	function automatic logic br_expect(input logic [2:0] f3, input logic [31:0] a, b);
		case (f3)
			`RV_F3_BEQ:  return a == b;
			`RV_F3_BNE:  return a != b;
			`RV_F3_BLT:  return $signed(a) < $signed(b);
			`RV_F3_BGE:  return $signed(a) >= $signed(b);
			`RV_F3_BLTU: return a < b;
			default:     return a >= b;
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s %s expected %08h actual %08h", test_name, what, exp, act);
			$display("Result: FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic clear_fwd();
		ex_w_en_i    = 1'b0;
		ex_is_load_i = 1'b0;
		ex_w_addr_i  = '0;
		ex_w_data_i  = '0;
		mem_w_en_i   = 1'b0;
		mem_w_addr_i = '0;
		mem_w_data_i = '0;
	endtask

	// starts on a falling edge and returns on the next one with the result registered
	task automatic issue(input logic [31:0] pc, input logic [31:0] inst, input logic valid);
		pc_i         = pc;
		inst_i       = inst;
		inst_valid_i = valid;
		#1;
		stall_seen = stall_o;
		@(negedge clk);
	endtask

	// register file request for the instruction still on inst_i
	task automatic rf_request(input logic e1, e2, input logic [4:0] a1, a2);
		check("r1_en", 32'(e1), 32'(r1_en_o));
		check("r2_en", 32'(e2), 32'(r2_en_o));
		check("r1_addr", 32'(a1), 32'(r1_addr_o));
		check("r2_addr", 32'(a2), 32'(r2_addr_o));
	endtask

	task automatic check_op(input logic [4:0] op, input logic [2:0] sel,
		input logic [31:0] o1, o2, input logic [4:0] rd);
		check("valid", 1, 32'(valid_o));
		check("aluop", 32'(op), 32'(aluop_o));
		check("alusel", 32'(sel), 32'(alusel_o));
		check("op1", o1, op1_o);
		check("op2", o2, op2_o);
		check("w_en", 1, 32'(w_en_o));
		check("w_addr", 32'(rd), 32'(w_addr_o));
	endtask

	task automatic reset_state();
		test_name = "reset";
		check("valid", 0, 32'(valid_o));
		check("w_en", 0, 32'(w_en_o));
		check("b_flag", 0, 32'(b_flag_o));
		check("illegal", 0, 32'(illegal_o));
	endtask

	task automatic alu_ops();
		logic [4:0]		rs1;
		logic [4:0]		rs2;
		logic [4:0]		rd;
		logic [31:0]	r;
		logic [11:0]	imm;
		test_name = "alu";
		rs1 = rnd_reg();
		rs2 = rnd_reg();
		rd  = rnd_reg();
		r   = $urandom();
		issue(32'h100, r_type(1'b0, rs2, rs1, `RV_F3_ADD, rd), 1'b1);
		rf_request(1'b1, 1'b1, rs1, rs2);
		check_op(rv_id_pkg::ALU_ADD, rv_id_pkg::SEL_ARITH, rf_val(rs1), rf_val(rs2), rd);
		issue(32'h104, r_type(1'b1, rs2, rs1, `RV_F3_ADD, rd), 1'b1);
		check_op(rv_id_pkg::ALU_SUB, rv_id_pkg::SEL_ARITH, rf_val(rs1), rf_val(rs2), rd);
		issue(32'h108, r_type(1'b1, rs2, rs1, `RV_F3_SR, rd), 1'b1);
		check_op(rv_id_pkg::ALU_SRA, rv_id_pkg::SEL_SHIFT, rf_val(rs1), rf_val(rs2), rd);
		issue(32'h10c, r_type(1'b0, rs2, rs1, `RV_F3_XOR, rd), 1'b1);
		check_op(rv_id_pkg::ALU_XOR, rv_id_pkg::SEL_LOGIC, rf_val(rs1), rf_val(rs2), rd);
		// negative immediate sign extended for addi
		imm = {1'b1, r[10:0]};
		issue(32'h110, i_type(`RV_OP_OPI, imm, rs1, `RV_F3_ADD, rd), 1'b1);
		rf_request(1'b1, 1'b0, rs1, imm[4:0]);
		check_op(rv_id_pkg::ALU_ADD, rv_id_pkg::SEL_ARITH, rf_val(rs1), {20'hfffff, imm}, rd);
		// same bits zero extended for andi
		issue(32'h114, i_type(`RV_OP_OPI, imm, rs1, `RV_F3_AND, rd), 1'b1);
		check_op(rv_id_pkg::ALU_AND, rv_id_pkg::SEL_LOGIC, rf_val(rs1), {20'h0, imm}, rd);
		imm = {7'b0100000, r[15:11]};
		issue(32'h118, i_type(`RV_OP_OPI, imm, rs1, `RV_F3_SR, rd), 1'b1);
		check_op(rv_id_pkg::ALU_SRA, rv_id_pkg::SEL_SHIFT, rf_val(rs1), {27'b0, r[15:11]}, rd);
		// sltiu sign extends as well
		imm = {1'b1, r[26:16]};
		issue(32'h11c, i_type(`RV_OP_OPI, imm, rs1, `RV_F3_SLTU, rd), 1'b1);
		check_op(rv_id_pkg::ALU_SLTU, rv_id_pkg::SEL_ARITH, rf_val(rs1), {20'hfffff, imm}, rd);
	endtask

	task automatic upper_and_loads();
		logic [2:0]		ld_f3 [5];
		logic [4:0]		ld_op [5];
		logic [4:0]		rs1;
		logic [4:0]		rd;
		logic [31:0]	r;
		logic [31:0]	uimm;
		logic [31:0]	simm;
		test_name = "upper_load";
		ld_f3 = '{`RV_F3_LB, `RV_F3_LH, `RV_F3_LW, `RV_F3_LBU, `RV_F3_LHU};
		ld_op = '{rv_id_pkg::ALU_LB, rv_id_pkg::ALU_LH, rv_id_pkg::ALU_LW,
			rv_id_pkg::ALU_LBU, rv_id_pkg::ALU_LHU};
		rd   = rnd_reg();
		r    = $urandom();
		uimm = {r[31:12], 12'h0};
		// lui reads the immediate on both sources
		issue(32'h200, {r[31:12], rd, `RV_OP_LUI}, 1'b1);
		rf_request(1'b0, 1'b0, r[19:15], r[24:20]);
		check_op(rv_id_pkg::ALU_OR, rv_id_pkg::SEL_LOGIC, uimm, uimm, rd);
		check("offset", uimm, offset_o);
		issue(32'h204, {r[31:12], rd, `RV_OP_AUIPC}, 1'b1);
		check_op(rv_id_pkg::ALU_AUIPC, rv_id_pkg::SEL_ARITH, uimm, uimm, rd);
		check("offset", uimm, offset_o);
		check("pc", 32'h204, pc_o);
		for (int i = 0; i < 5; i++) begin
			rs1  = rnd_reg();
			rd   = rnd_reg();
			r    = $urandom();
			simm = {{20{r[11]}}, r[11:0]};
			issue(32'h210, i_type(`RV_OP_LOAD, r[11:0], rs1, ld_f3[i], rd), 1'b1);
			rf_request(1'b1, 1'b0, rs1, r[4:0]);
			check_op(ld_op[i], rv_id_pkg::SEL_LD, rf_val(rs1), simm, rd);
			check("offset", simm, offset_o);
		end
	endtask

	task automatic forwarding();
		test_name = "forward";
		// execute wins when both stages match rs1
		ex_w_en_i    = 1'b1;
		ex_w_addr_i  = 5'd9;
		ex_w_data_i  = 32'haaaa_0001;
		mem_w_en_i   = 1'b1;
		mem_w_addr_i = 5'd9;
		mem_w_data_i = 32'hbbbb_0002;
		issue(32'h300, r_type(1'b0, 5'd17, 5'd9, `RV_F3_ADD, 5'd3), 1'b1);
		check("op1", 32'haaaa_0001, op1_o);
		check("op2", rf_val(5'd17), op2_o);
		ex_w_addr_i = 5'd17;
		issue(32'h304, r_type(1'b0, 5'd17, 5'd9, `RV_F3_ADD, 5'd3), 1'b1);
		check("op1", 32'hbbbb_0002, op1_o);
		check("op2", 32'haaaa_0001, op2_o);
		// matching addresses but no write enables
		ex_w_en_i   = 1'b0;
		ex_w_addr_i = 5'd9;
		mem_w_en_i  = 1'b0;
		issue(32'h308, r_type(1'b0, 5'd17, 5'd9, `RV_F3_ADD, 5'd3), 1'b1);
		check("op1", rf_val(5'd9), op1_o);
		ex_w_en_i    = 1'b1;
		ex_w_addr_i  = 5'd0;
		mem_w_en_i   = 1'b1;
		mem_w_addr_i = 5'd0;
		issue(32'h30c, r_type(1'b0, 5'd17, 5'd0, `RV_F3_ADD, 5'd3), 1'b1);
		check("op1", 0, op1_o);
		check("op2", rf_val(5'd17), op2_o);
		clear_fwd();
	endtask

	task automatic load_use();
		logic [31:0] inst;
		test_name = "load_use";
		inst = r_type(1'b0, 5'd17, 5'd9, `RV_F3_ADD, 5'd3);
		ex_w_en_i    = 1'b1;
		ex_is_load_i = 1'b1;
		ex_w_addr_i  = 5'd9;
		issue(32'h400, inst, 1'b1);
		check("stall", 1, 32'(stall_seen));
		check("valid", 0, 32'(valid_o));
		// load moved on to memory while fetch held the instruction
		clear_fwd();
		mem_w_en_i   = 1'b1;
		mem_w_addr_i = 5'd9;
		mem_w_data_i = 32'hcafe_0009;
		issue(32'h400, inst, 1'b1);
		check("stall", 0, 32'(stall_seen));
		check("valid", 1, 32'(valid_o));
		check("op1", 32'hcafe_0009, op1_o);
		ex_w_en_i    = 1'b1;
		ex_is_load_i = 1'b1;
		ex_w_addr_i  = 5'd17;
		issue(32'h404, inst, 1'b1);
		check("stall", 1, 32'(stall_seen));
		check("valid", 0, 32'(valid_o));
		clear_fwd();
		issue(32'h404, inst, 1'b1);
		check("valid", 1, 32'(valid_o));
		check("op2", rf_val(5'd17), op2_o);
		// load into x0 never stalls
		ex_w_en_i    = 1'b1;
		ex_is_load_i = 1'b1;
		issue(32'h408, r_type(1'b0, 5'd17, 5'd0, `RV_F3_ADD, 5'd3), 1'b1);
		check("stall", 0, 32'(stall_seen));
		check("valid", 1, 32'(valid_o));
		clear_fwd();
	endtask

	task automatic branches();
		logic [2:0]		f3 [6];
		logic [31:0]	va [4];
		logic [31:0]	vb [4];
		logic [31:0]	r;
		logic [31:0]	pc;
		logic [31:0]	exp_tgt;
		logic [4:0]		rd;
		test_name = "branch";
		f3 = '{`RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BLT, `RV_F3_BGE, `RV_F3_BLTU, `RV_F3_BGEU};
		va = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h8000_0000};
		vb = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h8000_0000};
		ex_w_en_i    = 1'b1;
		ex_w_addr_i  = 5'd9;
		mem_w_en_i   = 1'b1;
		mem_w_addr_i = 5'd17;
		for (int i = 0; i < 6; i++) begin
			for (int j = 0; j < 4; j++) begin
				r            = $urandom();
				pc           = {16'h0, r[31:18], 2'b00};
				exp_tgt      = pc + {{19{r[12]}}, r[12:1], 1'b0};
				ex_w_data_i  = va[j];
				mem_w_data_i = vb[j];
				issue(pc, b_type({r[12:1], 1'b0}, 5'd17, 5'd9, f3[i]), 1'b1);
				rf_request(1'b1, 1'b1, 5'd9, 5'd17);
				check("valid", 1, 32'(valid_o));
				check("b_flag", 32'(br_expect(f3[i], va[j], vb[j])), 32'(b_flag_o));
				check("b_target", exp_tgt, b_target_o);
				check("w_en", 0, 32'(w_en_o));
			end
		end
		r       = $urandom();
		rd      = rnd_reg();
		pc      = {16'h0, r[31:18], 2'b00};
		exp_tgt = pc + {{11{r[20]}}, r[20:1], 1'b0};
		issue(pc, j_type({r[20:1], 1'b0}, rd), 1'b1);
		check("b_flag", 1, 32'(b_flag_o));
		check("b_target", exp_tgt, b_target_o);
		check("aluop", 32'(rv_id_pkg::ALU_JAL), 32'(aluop_o));
		check("w_addr", 32'(rd), 32'(w_addr_o));
		// jalr base comes from execute and target bit 0 is cleared
		r           = $urandom();
		ex_w_data_i = {r[31:1], 1'b1};
		exp_tgt     = ({r[31:1], 1'b1} + {{20{r[11]}}, r[11:0]}) & 32'hffff_fffe;
		issue(pc, i_type(`RV_OP_JALR, r[11:0], 5'd9, 3'b000, rd), 1'b1);
		rf_request(1'b1, 1'b0, 5'd9, r[4:0]);
		check("b_flag", 1, 32'(b_flag_o));
		check("b_target", exp_tgt, b_target_o);
		check("aluop", 32'(rv_id_pkg::ALU_JALR), 32'(aluop_o));
		check("w_en", 1, 32'(w_en_o));
		clear_fwd();
	endtask

	task automatic illegal_and_bubble();
		logic [31:0] r;
		test_name = "illegal";
		r = $urandom();
		issue(32'h500, {r[31:7], 7'b1111111}, 1'b1);
		check("valid", 1, 32'(valid_o));
		check("illegal", 1, 32'(illegal_o));
		check("w_en", 0, 32'(w_en_o));
		check("b_flag", 0, 32'(b_flag_o));
		// sw x17, 0(x9)
		issue(32'h504, {7'b0, 5'd17, 5'd9, 3'b010, 5'b0, `RV_OP_STORE}, 1'b1);
		check("illegal", 1, 32'(illegal_o));
		check("w_en", 0, 32'(w_en_o));
		check("b_flag", 0, 32'(b_flag_o));
		// known opcode with funct7 not defined for xor
		issue(32'h508, r_type(1'b1, 5'd17, 5'd9, `RV_F3_XOR, 5'd3), 1'b1);
		check("illegal", 0, 32'(illegal_o));
		check("aluop", 32'(rv_id_pkg::ALU_NOP), 32'(aluop_o));
		check("w_en", 0, 32'(w_en_o));
		issue(32'h50c, r_type(1'b0, 5'd17, 5'd9, `RV_F3_ADD, 5'd3), 1'b0);
		check("valid", 0, 32'(valid_o));
		check("w_en", 0, 32'(w_en_o));
	endtask

	initial begin
		void'($urandom(13268));
		rst          = 1'b1;
		pc_i         = '0;
		inst_i       = '0;
		inst_valid_i = 1'b0;
		stall_seen   = 1'b0;
		clear_fwd();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		reset_state();
		alu_ops();
		upper_and_loads();
		forwarding();
		load_use();
		branches();
		illegal_and_bubble();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: tests/rv_id_asserts.sv
module rv_id_asserts (
	input logic	clk,
	input logic	rst,
	input logic	ex_is_load_i,
	input logic	stall_o,
	input logic	valid_o,
	input logic	w_en_o,
	input logic	b_flag_o
);

	// only a load in execute can hold fetch
	stall_needs_load: assert property (
		@(posedge clk) disable iff (rst) stall_o |-> ex_is_load_i
	) else $error("stall_o high without a load in execute");

	stall_gives_bubble: assert property (
		@(posedge clk) disable iff (rst) stall_o |=> !valid_o
	) else $error("valid_o high on the cycle after a stall");

	// bubbles carry no side effects
	bubble_is_quiet: assert property (
		@(posedge clk) disable iff (rst) !valid_o |-> (!w_en_o && !b_flag_o)
	) else $error("w_en_o or b_flag_o high while valid_o is low");

endmodule

// File: rtl/rv_id_stage.sv
`include "rv_id_consts.svh"

module rv_id_stage (
	input  logic					clk,
	input  logic					rst,
	input  logic [`RV_XLEN-1:0]		pc_i,
	input  logic [`RV_XLEN-1:0]		inst_i,
	input  logic					inst_valid_i,
	output logic					r1_en_o,
	output logic					r2_en_o,
	output logic [`RV_REG_AW-1:0]	r1_addr_o,
	output logic [`RV_REG_AW-1:0]	r2_addr_o,
	input  logic [`RV_XLEN-1:0]		r1_data_i,
	input  logic [`RV_XLEN-1:0]		r2_data_i,
	input  logic					ex_w_en_i,
	input  logic					ex_is_load_i,
	input  logic [`RV_REG_AW-1:0]	ex_w_addr_i,
	input  logic [`RV_XLEN-1:0]		ex_w_data_i,
	input  logic					mem_w_en_i,
	input  logic [`RV_REG_AW-1:0]	mem_w_addr_i,
	input  logic [`RV_XLEN-1:0]		mem_w_data_i,
	output logic					stall_o,
	output logic [`RV_XLEN-1:0]		pc_o,
	output rv_id_pkg::alu_op_e		aluop_o,
	output rv_id_pkg::alu_sel_e		alusel_o,
	output logic [`RV_XLEN-1:0]		op1_o,
	output logic [`RV_XLEN-1:0]		op2_o,
	output logic					w_en_o,
	output logic [`RV_REG_AW-1:0]	w_addr_o,
	output logic [`RV_XLEN-1:0]		offset_o,
	output logic					b_flag_o,
	output logic [`RV_XLEN-1:0]		b_target_o,
	output logic					illegal_o,
	output logic					valid_o
);

	rv_id_pkg::alu_op_e		aluop;
	rv_id_pkg::alu_sel_e	alusel;
	rv_id_pkg::imm_fmt_e	fmt;
	rv_id_pkg::br_kind_e	br_kind;
	logic					br_unsigned;
	logic					w_en;
	logic					illegal;
	logic [`RV_REG_AW-1:0]	rd;
	logic [`RV_XLEN-1:0]	imm;
	logic [`RV_XLEN-1:0]	op1;
	logic [`RV_XLEN-1:0]	op2;
	logic					stall_r1;
	logic					stall_r2;
	logic					b_flag;
	logic [`RV_XLEN-1:0]	b_target;

	imm_gen u_imm_gen (
		.inst_i	(inst_i),
		.fmt_i	(fmt),
		.rs1_o	(r1_addr_o),
		.rs2_o	(r2_addr_o),
		.rd_o	(rd),
		.imm_o	(imm)
	);

	// is_load only matters once the instruction reaches execute
	ctrl_decoder u_ctrl_decoder (
		.inst_i			(inst_i),
		.aluop_o		(aluop),
		.alusel_o		(alusel),
		.fmt_o			(fmt),
		.br_kind_o		(br_kind),
		.br_unsigned_o	(br_unsigned),
		.r1_en_o		(r1_en_o),
		.r2_en_o		(r2_en_o),
		.w_en_o			(w_en),
		.is_load_o		(),
		.illegal_o		(illegal)
	);

	operand_fwd u_fwd_r1 (
		.en_i			(r1_en_o),
		.addr_i			(r1_addr_o),
		.rf_data_i		(r1_data_i),
		.imm_i			(imm),
		.ex_w_en_i		(ex_w_en_i),
		.ex_is_load_i	(ex_is_load_i),
		.ex_w_addr_i	(ex_w_addr_i),
		.ex_w_data_i	(ex_w_data_i),
		.mem_w_en_i		(mem_w_en_i),
		.mem_w_addr_i	(mem_w_addr_i),
		.mem_w_data_i	(mem_w_data_i),
		.data_o			(op1),
		.stall_req_o	(stall_r1)
	);

	operand_fwd u_fwd_r2 (
		.en_i			(r2_en_o),
		.addr_i			(r2_addr_o),
		.rf_data_i		(r2_data_i),
		.imm_i			(imm),
		.ex_w_en_i		(ex_w_en_i),
		.ex_is_load_i	(ex_is_load_i),
		.ex_w_addr_i	(ex_w_addr_i),
		.ex_w_data_i	(ex_w_data_i),
		.mem_w_en_i		(mem_w_en_i),
		.mem_w_addr_i	(mem_w_addr_i),
		.mem_w_data_i	(mem_w_data_i),
		.data_o			(op2),
		.stall_req_o	(stall_r2)
	);

	branch_resolve u_branch_resolve (
		.br_kind_i		(br_kind),
		.br_unsigned_i	(br_unsigned),
		.pc_i			(pc_i),
		.imm_i			(imm),
		.op1_i			(op1),
		.op2_i			(op2),
		.b_flag_o		(b_flag),
		.b_target_o		(b_target)
	);

	id_ex_reg u_id_ex_reg (
		.clk			(clk),
		.rst			(rst),
		.inst_valid_i	(inst_valid_i),
		.stall_r1_i		(stall_r1),
		.stall_r2_i		(stall_r2),
		.pc_i			(pc_i),
		.aluop_i		(aluop),
		.alusel_i		(alusel),
		.op1_i			(op1),
		.op2_i			(op2),
		.w_en_i			(w_en),
		.w_addr_i		(rd),
		.offset_i		(imm),
		.b_flag_i		(b_flag),
		.b_target_i		(b_target),
		.illegal_i		(illegal),
		.stall_o		(stall_o),
		.pc_o			(pc_o),
		.aluop_o		(aluop_o),
		.alusel_o		(alusel_o),
		.op1_o			(op1_o),
		.op2_o			(op2_o),
		.w_en_o			(w_en_o),
		.w_addr_o		(w_addr_o),
		.offset_o		(offset_o),
		.b_flag_o		(b_flag_o),
		.b_target_o		(b_target_o),
		.illegal_o		(illegal_o),
		.valid_o		(valid_o)
	);

endmodule

// File: rtl/id_ex_reg.sv
`include "rv_id_consts.svh"

module id_ex_reg (
	input  logic					clk,
	input  logic					rst,
	input  logic					inst_valid_i,
	input  logic					stall_r1_i,
	input  logic					stall_r2_i,
	input  logic [`RV_XLEN-1:0]		pc_i,
	input  rv_id_pkg::alu_op_e		aluop_i,
	input  rv_id_pkg::alu_sel_e		alusel_i,
	input  logic [`RV_XLEN-1:0]		op1_i,
	input  logic [`RV_XLEN-1:0]		op2_i,
	input  logic					w_en_i,
	input  logic [`RV_REG_AW-1:0]	w_addr_i,
	input  logic [`RV_XLEN-1:0]		offset_i,
	input  logic					b_flag_i,
	input  logic [`RV_XLEN-1:0]		b_target_i,
	input  logic					illegal_i,
	output logic					stall_o,
	output logic [`RV_XLEN-1:0]		pc_o,
	output rv_id_pkg::alu_op_e		aluop_o,
	output rv_id_pkg::alu_sel_e		alusel_o,
	output logic [`RV_XLEN-1:0]		op1_o,
	output logic [`RV_XLEN-1:0]		op2_o,
	output logic					w_en_o,
	output logic [`RV_REG_AW-1:0]	w_addr_o,
	output logic [`RV_XLEN-1:0]		offset_o,
	output logic					b_flag_o,
	output logic [`RV_XLEN-1:0]		b_target_o,
	output logic					illegal_o,
	output logic					valid_o
);

	logic take;

	// an empty slot never holds fetch
	assign stall_o = inst_valid_i && (stall_r1_i || stall_r2_i);
	assign take    = inst_valid_i && !stall_o;

	always_ff @(posedge clk) begin
		if (rst || !take) begin
			valid_o   <= 1'b0;
			w_en_o    <= 1'b0;
			b_flag_o  <= 1'b0;
			illegal_o <= 1'b0;
			aluop_o   <= rv_id_pkg::ALU_NOP;
			alusel_o  <= rv_id_pkg::SEL_NOP;
		end else begin
			valid_o   <= 1'b1;
			w_en_o    <= w_en_i;
			b_flag_o  <= b_flag_i;
			illegal_o <= illegal_i;
			aluop_o   <= aluop_i;
			alusel_o  <= alusel_i;
		end
	end

	always_ff @(posedge clk) begin
		pc_o       <= pc_i;
		op1_o      <= op1_i;
		op2_o      <= op2_i;
		w_addr_o   <= w_addr_i;
		offset_o   <= offset_i;
		b_target_o <= b_target_i;
	end

endmodule

// File: rtl/branch_resolve.sv
`include "rv_id_consts.svh"

module branch_resolve (
	input  rv_id_pkg::br_kind_e		br_kind_i,
	input  logic					br_unsigned_i,
	input  logic [`RV_XLEN-1:0]		pc_i,
	input  logic [`RV_XLEN-1:0]		imm_i,
	input  logic [`RV_XLEN-1:0]		op1_i,
	input  logic [`RV_XLEN-1:0]		op2_i,
	output logic					b_flag_o,
	output logic [`RV_XLEN-1:0]		b_target_o
);

	logic [`RV_XLEN-1:0]	pc_rel;
	logic [`RV_XLEN-1:0]	reg_rel;
	logic					eq;
	logic					lt;

	assign pc_rel  = pc_i + imm_i;
	assign reg_rel = op1_i + imm_i;
	assign eq      = (op1_i == op2_i);
	assign lt      = br_unsigned_i ? (op1_i < op2_i) : ($signed(op1_i) < $signed(op2_i));

	always_comb begin
		b_flag_o   = 1'b0;
		b_target_o = pc_rel;
		case (br_kind_i)
			rv_id_pkg::BR_JAL:  b_flag_o = 1'b1;
			rv_id_pkg::BR_JALR: begin
				b_flag_o   = 1'b1;
				b_target_o = {reg_rel[`RV_XLEN-1:1], 1'b0};
			end
			rv_id_pkg::BR_EQ:   b_flag_o = eq;
			rv_id_pkg::BR_NE:   b_flag_o = !eq;
			rv_id_pkg::BR_LT:   b_flag_o = lt;
			rv_id_pkg::BR_GE:   b_flag_o = !lt;
			default:            b_target_o = '0;
		endcase
	end

endmodule

// File: rtl/operand_fwd.sv
`include "rv_id_consts.svh"

module operand_fwd (
	input  logic					en_i,
	input  logic [`RV_REG_AW-1:0]	addr_i,
	input  logic [`RV_XLEN-1:0]		rf_data_i,
	input  logic [`RV_XLEN-1:0]		imm_i,
	input  logic					ex_w_en_i,
	input  logic					ex_is_load_i,
	input  logic [`RV_REG_AW-1:0]	ex_w_addr_i,
	input  logic [`RV_XLEN-1:0]		ex_w_data_i,
	input  logic					mem_w_en_i,
	input  logic [`RV_REG_AW-1:0]	mem_w_addr_i,
	input  logic [`RV_XLEN-1:0]		mem_w_data_i,
	output logic [`RV_XLEN-1:0]		data_o,
	output logic					stall_req_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = (ex_w_addr_i == addr_i);
	assign mem_hit = mem_w_en_i && (mem_w_addr_i == addr_i);

	always_comb begin
		stall_req_o = 1'b0;
		data_o      = rf_data_i;
		if (!en_i) begin
			data_o = imm_i;
		end else if (addr_i != `RV_NOP_REG) begin
			// load result not ready until mem, wait a cycle
			if (ex_is_load_i && ex_hit)
				stall_req_o = 1'b1;
			else if (ex_w_en_i && ex_hit)
				data_o = ex_w_data_i;
			else if (mem_hit)
				data_o = mem_w_data_i;
		end
	end

endmodule

// File: rtl/ctrl_decoder.sv
`include "rv_id_consts.svh"

module ctrl_decoder (
	input  logic [`RV_XLEN-1:0]		inst_i,
	output rv_id_pkg::alu_op_e		aluop_o,
	output rv_id_pkg::alu_sel_e		alusel_o,
	output rv_id_pkg::imm_fmt_e		fmt_o,
	output rv_id_pkg::br_kind_e		br_kind_o,
	output logic					br_unsigned_o,
	output logic					r1_en_o,
	output logic					r2_en_o,
	output logic					w_en_o,
	output logic					is_load_o,
	output logic					illegal_o
);

	logic [6:0]	opcode;
	logic [2:0]	funct3;
	logic		alt;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign alt    = inst_i[`RV_F7_ALT];

	always_comb begin
		aluop_o       = rv_id_pkg::ALU_NOP;
		alusel_o      = rv_id_pkg::SEL_NOP;
		fmt_o         = rv_id_pkg::IMM_NONE;
		br_kind_o     = rv_id_pkg::BR_NONE;
		br_unsigned_o = 1'b0;
		r1_en_o       = 1'b0;
		r2_en_o       = 1'b0;
		w_en_o        = 1'b0;
		is_load_o     = 1'b0;
		illegal_o     = 1'b0;
		case (opcode)
			// lui is imm | imm, both sources read the immediate
			`RV_OP_LUI: begin
				aluop_o  = rv_id_pkg::ALU_OR;
				alusel_o = rv_id_pkg::SEL_LOGIC;
				fmt_o    = rv_id_pkg::IMM_U;
				w_en_o   = 1'b1;
			end
			`RV_OP_AUIPC: begin
				aluop_o  = rv_id_pkg::ALU_AUIPC;
				alusel_o = rv_id_pkg::SEL_ARITH;
				fmt_o    = rv_id_pkg::IMM_U;
				w_en_o   = 1'b1;
			end
			`RV_OP_JAL: begin
				aluop_o   = rv_id_pkg::ALU_JAL;
				alusel_o  = rv_id_pkg::SEL_JB;
				fmt_o     = rv_id_pkg::IMM_J;
				br_kind_o = rv_id_pkg::BR_JAL;
				w_en_o    = 1'b1;
			end
			`RV_OP_JALR: begin
				aluop_o   = rv_id_pkg::ALU_JALR;
				alusel_o  = rv_id_pkg::SEL_JB;
				fmt_o     = rv_id_pkg::IMM_I_SIGNED;
				br_kind_o = rv_id_pkg::BR_JALR;
				r1_en_o   = 1'b1;
				w_en_o    = 1'b1;
			end
			`RV_OP_BRANCH: begin
				case (funct3)
					`RV_F3_BEQ: begin
						aluop_o   = rv_id_pkg::ALU_BEQ;
						br_kind_o = rv_id_pkg::BR_EQ;
					end
					`RV_F3_BNE: begin
						aluop_o   = rv_id_pkg::ALU_BNE;
						br_kind_o = rv_id_pkg::BR_NE;
					end
					`RV_F3_BLT: begin
						aluop_o   = rv_id_pkg::ALU_BLT;
						br_kind_o = rv_id_pkg::BR_LT;
					end
					`RV_F3_BGE: begin
						aluop_o   = rv_id_pkg::ALU_BGE;
						br_kind_o = rv_id_pkg::BR_GE;
					end
					`RV_F3_BLTU: begin
						aluop_o       = rv_id_pkg::ALU_BLTU;
						br_kind_o     = rv_id_pkg::BR_LT;
						br_unsigned_o = 1'b1;
					end
					`RV_F3_BGEU: begin
						aluop_o       = rv_id_pkg::ALU_BGEU;
						br_kind_o     = rv_id_pkg::BR_GE;
						br_unsigned_o = 1'b1;
					end
					default: ;
				endcase
				if (aluop_o != rv_id_pkg::ALU_NOP) begin
					fmt_o   = rv_id_pkg::IMM_B;
					r1_en_o = 1'b1;
					r2_en_o = 1'b1;
				end
			end
			`RV_OP_LOAD: begin
				case (funct3)
					`RV_F3_LB:  aluop_o = rv_id_pkg::ALU_LB;
					`RV_F3_LH:  aluop_o = rv_id_pkg::ALU_LH;
					`RV_F3_LW:  aluop_o = rv_id_pkg::ALU_LW;
					`RV_F3_LBU: aluop_o = rv_id_pkg::ALU_LBU;
					`RV_F3_LHU: aluop_o = rv_id_pkg::ALU_LHU;
					default: ;
				endcase
				if (aluop_o != rv_id_pkg::ALU_NOP) begin
					alusel_o  = rv_id_pkg::SEL_LD;
					fmt_o     = rv_id_pkg::IMM_I_SIGNED;
					r1_en_o   = 1'b1;
					w_en_o    = 1'b1;
					is_load_o = 1'b1;
				end
			end
			`RV_OP_OPI: begin
				alusel_o = rv_id_pkg::SEL_ARITH;
				fmt_o    = rv_id_pkg::IMM_I_SIGNED;
				case (funct3)
					`RV_F3_ADD:  aluop_o = rv_id_pkg::ALU_ADD;
					`RV_F3_SLT:  aluop_o = rv_id_pkg::ALU_SLT;
					`RV_F3_SLTU: aluop_o = rv_id_pkg::ALU_SLTU;
					default: begin
						aluop_o  = (funct3 == `RV_F3_XOR) ? rv_id_pkg::ALU_XOR :
							(funct3 == `RV_F3_OR) ? rv_id_pkg::ALU_OR : rv_id_pkg::ALU_AND;
						alusel_o = rv_id_pkg::SEL_LOGIC;
						fmt_o    = rv_id_pkg::IMM_I_ZERO;
					end
					`RV_F3_SLL, `RV_F3_SR: begin
						if (funct3 == `RV_F3_SR)
							aluop_o = alt ? rv_id_pkg::ALU_SRA : rv_id_pkg::ALU_SRL;
						else if (!alt)
							aluop_o = rv_id_pkg::ALU_SLL;
						alusel_o = rv_id_pkg::SEL_SHIFT;
						fmt_o    = rv_id_pkg::IMM_SHAMT;
					end
				endcase
				if (aluop_o != rv_id_pkg::ALU_NOP) begin
					r1_en_o = 1'b1;
					w_en_o  = 1'b1;
				end else begin
					alusel_o = rv_id_pkg::SEL_NOP;
					fmt_o    = rv_id_pkg::IMM_NONE;
				end
			end
			`RV_OP_OP: begin
				case (funct3)
					`RV_F3_ADD:  aluop_o = alt ? rv_id_pkg::ALU_SUB : rv_id_pkg::ALU_ADD;
					`RV_F3_SLT:  aluop_o = rv_id_pkg::ALU_SLT;
					`RV_F3_SLTU: aluop_o = rv_id_pkg::ALU_SLTU;
					`RV_F3_XOR:  aluop_o = rv_id_pkg::ALU_XOR;
					`RV_F3_OR:   aluop_o = rv_id_pkg::ALU_OR;
					`RV_F3_AND:  aluop_o = rv_id_pkg::ALU_AND;
					`RV_F3_SLL:  aluop_o = rv_id_pkg::ALU_SLL;
					default:     aluop_o = alt ? rv_id_pkg::ALU_SRA : rv_id_pkg::ALU_SRL;
				endcase
				case (aluop_o)
					rv_id_pkg::ALU_XOR, rv_id_pkg::ALU_OR, rv_id_pkg::ALU_AND:
						alusel_o = rv_id_pkg::SEL_LOGIC;
					rv_id_pkg::ALU_SLL, rv_id_pkg::ALU_SRL, rv_id_pkg::ALU_SRA:
						alusel_o = rv_id_pkg::SEL_SHIFT;
					default:
						alusel_o = rv_id_pkg::SEL_ARITH;
				endcase
				// alt only valid on add/sub and srl/sra
				if (alt && funct3 != `RV_F3_ADD && funct3 != `RV_F3_SR) begin
					aluop_o  = rv_id_pkg::ALU_NOP;
					alusel_o = rv_id_pkg::SEL_NOP;
				end else begin
					r1_en_o = 1'b1;
					r2_en_o = 1'b1;
					w_en_o  = 1'b1;
				end
			end
			// stores land here too
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

// File: rtl/imm_gen.sv
`include "rv_id_consts.svh"

module imm_gen (
	input  logic [`RV_XLEN-1:0]		inst_i,
	input  rv_id_pkg::imm_fmt_e		fmt_i,
	output logic [`RV_REG_AW-1:0]	rs1_o,
	output logic [`RV_REG_AW-1:0]	rs2_o,
	output logic [`RV_REG_AW-1:0]	rd_o,
	output logic [`RV_XLEN-1:0]		imm_o
);

	logic sign;

	assign rd_o  = inst_i[11:7];
	assign rs1_o = inst_i[19:15];
	assign rs2_o = inst_i[24:20];
	assign sign  = inst_i[31];

	always_comb begin
		case (fmt_i)
			rv_id_pkg::IMM_I_SIGNED:
				imm_o = {{(`RV_XLEN-12){sign}}, inst_i[31:20]};
			// logical ops take the raw 12 bits
			rv_id_pkg::IMM_I_ZERO:
				imm_o = {{(`RV_XLEN-12){1'b0}}, inst_i[31:20]};
			rv_id_pkg::IMM_SHAMT:
				imm_o = {{(`RV_XLEN-`RV_REG_AW){1'b0}}, rs2_o};
			rv_id_pkg::IMM_U:
				imm_o = {inst_i[31:12], 12'h0};
			rv_id_pkg::IMM_B:
				imm_o = {{(`RV_XLEN-12){sign}}, inst_i[7], inst_i[30:25],
					inst_i[11:8], 1'b0};
			rv_id_pkg::IMM_J:
				imm_o = {{(`RV_XLEN-20){sign}}, inst_i[19:12], inst_i[20],
					inst_i[30:21], 1'b0};
			default:
				imm_o = '0;
		endcase
	end

endmodule

// File: rtl/rv_id_pkg.sv
package rv_id_pkg;

	// operation handed to execute
	typedef enum logic [4:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_AUIPC,
		ALU_JAL,
		ALU_JALR,
		ALU_BEQ,
		ALU_BNE,
		ALU_BLT,
		ALU_BGE,
		ALU_BLTU,
		ALU_BGEU,
		ALU_LB,
		ALU_LH,
		ALU_LW,
		ALU_LBU,
		ALU_LHU
	} alu_op_e;

	// result class, picks the execute result mux
	typedef enum logic [2:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_ARITH,
		SEL_SHIFT,
		SEL_JB,
		SEL_LD
	} alu_sel_e;

	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_I_SIGNED,
		IMM_I_ZERO,
		IMM_SHAMT,
		IMM_U,
		IMM_B,
		IMM_J
	} imm_fmt_e;

	// unsigned compares reuse LT and GE
	typedef enum logic [2:0] {
		BR_NONE,
		BR_JAL,
		BR_JALR,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE
	} br_kind_e;

endpackage

// File: rtl/rv_id_consts.svh
`ifndef RV_ID_CONSTS_SVH
`define RV_ID_CONSTS_SVH

`define RV_XLEN		32
`define RV_REG_AW	5
`define RV_NOP_REG	5'd0

// major opcodes
`define RV_OP_LUI		7'b0110111
`define RV_OP_AUIPC		7'b0010111
`define RV_OP_JAL		7'b1101111
`define RV_OP_JALR		7'b1100111
`define RV_OP_BRANCH	7'b1100011
`define RV_OP_LOAD		7'b0000011
`define RV_OP_OPI		7'b0010011
`define RV_OP_OP		7'b0110011
// not decoded by this stage
`define RV_OP_STORE		7'b0100011

// OP and OP-IMM
`define RV_F3_ADD	3'b000
`define RV_F3_SLL	3'b001
`define RV_F3_SLT	3'b010
`define RV_F3_SLTU	3'b011
`define RV_F3_XOR	3'b100
`define RV_F3_SR	3'b101
`define RV_F3_OR	3'b110
`define RV_F3_AND	3'b111

// branches
`define RV_F3_BEQ	3'b000
`define RV_F3_BNE	3'b001
`define RV_F3_BLT	3'b100
`define RV_F3_BGE	3'b101
`define RV_F3_BLTU	3'b110
`define RV_F3_BGEU	3'b111

// loads
`define RV_F3_LB	3'b000
`define RV_F3_LH	3'b001
`define RV_F3_LW	3'b010
`define RV_F3_LBU	3'b100
`define RV_F3_LHU	3'b101

// bit 30 picks SUB and SRA
`define RV_F7_ALT	30

`endif
